// File: rtl/mem_sys_pkg.sv
/*
 * Shared types, geometry and timing constants for the cached memory system.
 * Imported by every RTL block and by the testbench.
 */
package mem_sys_pkg;

   // Address fields, high to low: tag, index, offset
   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;
   typedef logic [4:0]  tag_t;
   typedef logic [7:0]  index_t;
   typedef logic [2:0]  offset_t;

   localparam int NUM_SETS       = 256;
   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);

   // Each bank holds one word of every line
   localparam int ROW_BITS  = $bits(addr_t) - $bits(offset_t);
   localparam int BANK_ROWS = 2 ** ROW_BITS;

   localparam int MEM_RD_LATENCY   = 2;
   localparam int BANK_BUSY_CYCLES = 4;
   localparam int BUSY_W           = $clog2(BANK_BUSY_CYCLES + 1);

   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WB_REQ,
      FILL_REQ,
      FILL_WAIT,
      FINISH,
      DONE
   } ctrl_state_e;

endpackage

// File: rtl/cache_way_if.sv
/*
 * Signals between the cache controller and one cache way.
 * The controller takes the ctrl modport, the way takes the way modport.
 */
`timescale 1ns/10ps

interface cache_way_if;
   import mem_sys_pkg::*;

   logic    enable;
   logic    comp;
   logic    write;
   index_t  index;
   offset_t offset;
   tag_t    tag_in;
   word_t   data_in;
   logic    valid_in;

   logic    hit;
   logic    dirty;
   logic    valid;
   tag_t    tag_out;
   word_t   data_out;

   modport ctrl (
      output enable, comp, write, index, offset, tag_in, data_in, valid_in,
      input  hit, dirty, valid, tag_out, data_out
   );

   modport way (
      input  enable, comp, write, index, offset, tag_in, data_in, valid_in,
      output hit, dirty, valid, tag_out, data_out
   );

endinterface

// File: rtl/cache_way.sv
/*
 * One way of the cache: tag, valid and dirty per set plus four data words.
 * Lookup is combinational; writes land on the clock edge.
 */
`timescale 1ns/10ps

module cache_way (
   input logic      clk,
   input logic      rst_n,
   cache_way_if.way bus
);
   import mem_sys_pkg::*;

   tag_t                     tags [NUM_SETS];
   word_t                    lines [NUM_SETS][WORDS_PER_LINE];
   logic [NUM_SETS-1:0]      valid_bits;
   logic [NUM_SETS-1:0]      dirty_bits;
   logic [WORD_SEL_BITS-1:0] word_sel;
   logic                     tag_match;
   logic                     do_write;

   assign word_sel  = bus.offset[WORD_SEL_BITS:1];
   assign tag_match = (tags[bus.index] == bus.tag_in);

   assign bus.valid    = valid_bits[bus.index];
   assign bus.dirty    = dirty_bits[bus.index];
   assign bus.tag_out  = tags[bus.index];
   assign bus.data_out = lines[bus.index][word_sel];
   assign bus.hit      = bus.enable && valid_bits[bus.index] && tag_match;

   // Compare-write only lands on a hit, access-write always lands
   assign do_write = bus.enable && bus.write && (!bus.comp || bus.hit);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (do_write) begin
         if (bus.comp) begin
            dirty_bits[bus.index] <= 1'b1;
         end else begin
            valid_bits[bus.index] <= bus.valid_in;
            dirty_bits[bus.index] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         lines[bus.index][word_sel] <= bus.data_in;
         if (!bus.comp) begin
            tags[bus.index] <= bus.tag_in;
         end
      end
   end

endmodule

// File: rtl/four_bank_mem.sv
/*
 * Behavioral main memory, four banks interleaved on the word offset.
 * Reads return after a fixed latency; a busy bank raises stall until it frees up.
 */
`timescale 1ns/10ps

module four_bank_mem (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t addr,
   input  mem_sys_pkg::word_t data_in,
   input  logic               rd,
   input  logic               wr,
   output mem_sys_pkg::word_t data_out,
   output logic               stall
);
   import mem_sys_pkg::*;

   word_t                    banks [WORDS_PER_LINE][BANK_ROWS] = '{default: '0};
   logic [BUSY_W-1:0]        busy_cnt [WORDS_PER_LINE];
   word_t                    rd_pipe [MEM_RD_LATENCY];
   logic [WORD_SEL_BITS-1:0] bank;
   logic [ROW_BITS-1:0]      row;
   logic                     accept;

   assign bank = addr[WORD_SEL_BITS:1];
   assign row  = addr[$bits(addr_t)-1 -: ROW_BITS];

   assign stall  = (rd || wr) && (busy_cnt[bank] != '0);
   assign accept = (rd || wr) && !stall;

   // Busy time per bank, restarted by every accepted access
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            if (accept && (bank == b)) begin
               busy_cnt[b] <= BUSY_W'(BANK_BUSY_CYCLES);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && wr) begin
         banks[bank][row] <= data_in;
      end
   end

   // Delay line, one stage per cycle of read latency
   always_ff @(posedge clk) begin
      rd_pipe[0] <= banks[bank][row];
      for (int i = 1; i < MEM_RD_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign data_out = rd_pipe[MEM_RD_LATENCY-1];

endmodule

// File: rtl/cache_ctrl_assoc.sv
/*
 * Blocking controller for the two-way cache. Handles hits, victim choice,
 * write-back and line fill, then replays the request. One request at a time.
 */
`timescale 1ns/10ps

module cache_ctrl_assoc (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t addr,
   input  mem_sys_pkg::word_t data_in,
   input  logic               rd,
   input  logic               wr,
   cache_way_if.ctrl          way0,
   cache_way_if.ctrl          way1,
   output mem_sys_pkg::addr_t mem_addr,
   output mem_sys_pkg::word_t mem_data_in,
   output logic               mem_rd,
   output logic               mem_wr,
   input  mem_sys_pkg::word_t mem_data_out,
   input  logic               mem_stall,
   output mem_sys_pkg::word_t data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);
   import mem_sys_pkg::*;

   ctrl_state_e              state;
   ctrl_state_e              state_nxt;
   addr_t                    req_addr;
   word_t                    req_data;
   tag_t                     req_tag;
   index_t                   req_idx;
   offset_t                  req_off;
   logic                     req_wr;
   logic                     req_err;
   logic                     req_hit;
   logic                     victim;
   logic                     victim_pick;
   logic                     victim_dirty;
   logic                     any_hit;
   logic                     accept;
   logic                     mem_accept;
   logic                     ret_valid;
   logic [WORD_SEL_BITS-1:0] iss_cnt;
   logic [WORD_SEL_BITS-1:0] rcv_cnt;
   logic [MEM_RD_LATENCY-1:0] rd_pipe;
   logic [NUM_SETS-1:0]      mru;
   word_t                    data_out_q;
   word_t                    hit_word;
   word_t                    victim_word;
   tag_t                     victim_tag;
   offset_t                  way_off;
   word_t                    way_data;
   logic                     way_comp;
   logic [1:0]               way_en;
   logic [1:0]               way_wr;

   assign {req_tag, req_idx, req_off} = req_addr;

   // The DONE cycle counts as idle, Stall is already low there
   assign accept     = ((state == IDLE) || (state == DONE)) && (rd || wr);
   assign mem_accept = (mem_rd || mem_wr) && !mem_stall;
   assign ret_valid  = rd_pipe[MEM_RD_LATENCY-1];

   assign any_hit  = way0.hit || way1.hit;
   assign hit_word = way1.hit ? way1.data_out : way0.data_out;

   // Invalid way first, then the way not used last
   assign victim_pick  = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : !mru[req_idx]);
   assign victim_dirty = victim_pick ? (way1.valid && way1.dirty)
                                     : (way0.valid && way0.dirty);
   assign victim_word  = victim ? way1.data_out : way0.data_out;
   assign victim_tag   = victim ? way1.tag_out : way0.tag_out;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: if (accept) state_nxt = COMPARE;
         COMPARE: begin
            if (req_err || any_hit) begin
               state_nxt = DONE;
            end else if (victim_dirty) begin
               state_nxt = WB_REQ;
            end else begin
               state_nxt = FILL_REQ;
            end
         end
         WB_REQ: if (mem_accept && (&iss_cnt)) state_nxt = FILL_REQ;
         FILL_REQ: if (mem_accept && (&iss_cnt)) state_nxt = FILL_WAIT;
         FILL_WAIT: if (ret_valid && (&rcv_cnt)) state_nxt = FINISH;
         FINISH: state_nxt = DONE;
         DONE: state_nxt = accept ? COMPARE : IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= IDLE;
         req_wr     <= 1'b0;
         req_err    <= 1'b0;
         req_hit    <= 1'b0;
         victim     <= 1'b0;
         iss_cnt    <= '0;
         rcv_cnt    <= '0;
         rd_pipe    <= '0;
         mru        <= '0;
         data_out_q <= '0;
      end else begin
         state   <= state_nxt;
         rd_pipe <= {rd_pipe[MEM_RD_LATENCY-2:0], mem_rd && !mem_stall};
         if (accept) begin
            req_wr  <= wr;
            req_err <= (rd && wr) || addr[0];
            req_hit <= 1'b0;
         end
         if (state == COMPARE) begin
            iss_cnt <= '0;
            rcv_cnt <= '0;
            victim  <= victim_pick;
            if (!req_err && any_hit) begin
               req_hit      <= 1'b1;
               mru[req_idx] <= way1.hit;
               if (!req_wr) data_out_q <= hit_word;
            end
         end
         // Counter wraps to zero between write-back and fill
         if (mem_accept) iss_cnt <= iss_cnt + 1'b1;
         if (ret_valid) rcv_cnt <= rcv_cnt + 1'b1;
         if (state == FINISH) begin
            mru[req_idx] <= victim;
            if (!req_wr) data_out_q <= victim_word;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
      end
   end

   // Way port drive, shared fields plus per-way enable and write
   always_comb begin
      way_off  = req_off;
      way_data = req_data;
      way_comp = 1'b0;
      way_en   = 2'b00;
      way_wr   = 2'b00;
      case (state)
         COMPARE: begin
            way_comp = 1'b1;
            way_en   = {2{!req_err}};
            way_wr   = {2{req_wr && !req_err}};
         end
         WB_REQ: way_off = {iss_cnt, 1'b0};
         FILL_REQ, FILL_WAIT: begin
            if (ret_valid) begin
               way_off        = {rcv_cnt, 1'b0};
               way_data       = mem_data_out;
               way_en[victim] = 1'b1;
               way_wr[victim] = 1'b1;
            end
         end
         FINISH: begin
            way_comp       = 1'b1;
            way_en[victim] = 1'b1;
            way_wr[victim] = req_wr;
         end
         default: ;
      endcase
   end

   assign way0.enable   = way_en[0];
   assign way0.comp     = way_comp;
   assign way0.write    = way_wr[0];
   assign way0.index    = req_idx;
   assign way0.offset   = way_off;
   assign way0.tag_in   = req_tag;
   assign way0.data_in  = way_data;
   assign way0.valid_in = 1'b1;

   assign way1.enable   = way_en[1];
   assign way1.comp     = way_comp;
   assign way1.write    = way_wr[1];
   assign way1.index    = req_idx;
   assign way1.offset   = way_off;
   assign way1.tag_in   = req_tag;
   assign way1.data_in  = way_data;
   assign way1.valid_in = 1'b1;

   // Write-back goes out under the victim's tag, fills under the request's
   assign mem_wr      = (state == WB_REQ);
   assign mem_rd      = (state == FILL_REQ);
   assign mem_addr    = (state == WB_REQ) ? {victim_tag, req_idx, iss_cnt, 1'b0}
                                          : {req_tag, req_idx, iss_cnt, 1'b0};
   assign mem_data_in = victim_word;

   assign done      = (state == DONE);
   assign stall     = (state != IDLE) && (state != DONE);
   assign cache_hit = done && req_hit;
   assign err       = done && req_err;
   assign data_out  = data_out_q;

endmodule

// File: rtl/mem_system.sv
/*
 * Top of the cached memory system: controller, two cache ways, banked memory.
 * Pulse Rd or Wr with Addr while Stall is low, then wait for Done.
 */
`timescale 1ns/10ps

module mem_system (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t Addr,
   input  mem_sys_pkg::word_t DataIn,
   input  logic               Rd,
   input  logic               Wr,
   output mem_sys_pkg::word_t DataOut,
   output logic               Done,
   output logic               Stall,
   output logic               CacheHit,
   output logic               err
);
   import mem_sys_pkg::*;

   addr_t mem_addr;
   word_t mem_data_in;
   word_t mem_data_out;
   logic  mem_rd;
   logic  mem_wr;
   logic  mem_stall;

   cache_way_if way0_bus ();
   cache_way_if way1_bus ();

   cache_way way0 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way0_bus.way)
   );

   cache_way way1 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way1_bus.way)
   );

   four_bank_mem mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .addr     (mem_addr),
      .data_in  (mem_data_in),
      .rd       (mem_rd),
      .wr       (mem_wr),
      .data_out (mem_data_out),
      .stall    (mem_stall)
   );

   cache_ctrl_assoc ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .addr         (Addr),
      .data_in      (DataIn),
      .rd           (Rd),
      .wr           (Wr),
      .way0         (way0_bus.ctrl),
      .way1         (way1_bus.ctrl),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .mem_data_out (mem_data_out),
      .mem_stall    (mem_stall),
      .data_out     (DataOut),
      .done         (Done),
      .stall        (Stall),
      .cache_hit    (CacheHit),
      .err          (err)
   );

endmodule

// File: test/tb_mem_system.sv
/*
 * Testbench for the two-way cached memory system. Directed hit, miss, eviction
 * and error requests, then random traffic on a few sets, checked on every Done.
 */
`timescale 1ns/10ps

module tb_mem_system;
   import mem_sys_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int NUM_DIRECTED = 17;
   localparam int NUM_RAND     = 300;
   localparam int NUM_REQS     = NUM_DIRECTED + NUM_RAND;
   localparam int MISS_WORST   = 40;
   localparam int MISS_MIN     = 1 + WORDS_PER_LINE + MEM_RD_LATENCY + 2;
   localparam int IDX_MASK     = 3;

   logic  clk = 1'b0;
   logic  rst_n;
   addr_t Addr;
   word_t DataIn;
   logic  Rd;
   logic  Wr;
   word_t DataOut;
   logic  Done;
   logic  Stall;
   logic  CacheHit;
   logic  err;

   integer seed = 32'h8e78;
   int     errors = 0;
   int     checks = 0;
   int     num_reqs = 0;
   int     cyc = 0;
   int     req_cyc = 0;
   logic   exp_err = 1'b0;
   logic   exp_hit = 1'b0;
   word_t  exp_data = '0;

   // Architectural memory image plus tag, valid and MRU per set
   word_t  mem_img [addr_t];
   tag_t   ref_tag [2][NUM_SETS];
   logic   ref_valid [2][NUM_SETS];
   logic   ref_mru [NUM_SETS];

   mem_system dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic addr_t make_addr(input tag_t t, input index_t idx, input logic [1:0] w);
      return {t, idx, w, 1'b0};
   endfunction

   // Predicts CacheHit and read data, and updates the reference state
   function automatic logic predict(input addr_t a, input logic is_wr, input word_t d,
                                    output word_t rdata);
      tag_t   t;
      index_t idx;
      logic   h0;
      logic   h1;
      logic   vic;
      t     = a[15:11];
      idx   = a[10:3];
      h0    = ref_valid[0][idx] && (ref_tag[0][idx] == t);
      h1    = ref_valid[1][idx] && (ref_tag[1][idx] == t);
      rdata = mem_img.exists(a) ? mem_img[a] : '0;
      if (is_wr) mem_img[a] = d;
      if (h0 || h1) begin
         ref_mru[idx] = h1;
         return 1'b1;
      end
      vic = !ref_valid[0][idx] ? 1'b0 : (!ref_valid[1][idx] ? 1'b1 : !ref_mru[idx]);
      ref_valid[vic][idx] = 1'b1;
      ref_tag[vic][idx]   = t;
      ref_mru[idx]        = vic;
      return 1'b0;
   endfunction

   // Pulses one request and waits for Done plus one idle cycle
   task automatic issue(input logic rd_i, input logic wr_i, input addr_t a, input word_t d);
      word_t rv;
      exp_err = (rd_i && wr_i) || a[0];
      exp_hit = 1'b0;
      if (!exp_err) begin
         exp_hit = predict(a, wr_i, d, rv);
         if (!wr_i) exp_data = rv;
      end
      req_cyc  = cyc;
      num_reqs = num_reqs + 1;
      Rd       = rd_i;
      Wr       = wr_i;
      Addr     = a;
      DataIn   = d;
      @(negedge clk);
      Rd = 1'b0;
      Wr = 1'b0;
      while (!Done) begin
         assert (Stall === 1'b1)
         else begin
            $display("ERR Stall: got %h, expected 1 (addr %h)", Stall, a);
            errors++;
         end
         @(negedge clk);
      end
      @(negedge clk);
      assert (Done === 1'b0)
      else begin
         $display("Done stayed high for more than one cycle (addr %h)", a);
         errors++;
      end
   endtask

   always @(negedge clk) begin
      if (rst_n && Done) begin
         checks++;
         assert (err === exp_err)
         else begin
            $display("ERR err: got %h, expected %h (addr %h)", err, exp_err, Addr);
            errors++;
         end
         assert (CacheHit === exp_hit)
         else begin
            $display("ERR CacheHit: got %h, expected %h (addr %h)", CacheHit, exp_hit, Addr);
            errors++;
         end
         assert (DataOut === exp_data)
         else begin
            $display("ERR DataOut: got %h, expected %h (addr %h)", DataOut, exp_data, Addr);
            errors++;
         end
         assert (Stall === 1'b0)
         else begin
            $display("ERR Stall: got %h, expected 0 with Done", Stall);
            errors++;
         end
         // Hits and errors finish one cycle after the accepting edge
         if (exp_err || exp_hit) begin
            assert (cyc - req_cyc == 2)
            else begin
               $display("Done came %0d cycles after the request instead of 2", cyc - req_cyc);
               errors++;
            end
         end else begin
            assert (cyc - req_cyc >= MISS_MIN)
            else begin
               $display("Miss finished after %0d cycles, fewer than %0d",
                        cyc - req_cyc, MISS_MIN);
               errors++;
            end
         end
      end
   end

   initial begin
      #(NUM_REQS * MISS_WORST * CLK_PERIOD + 10 * CLK_PERIOD);
      $display("Timeout: requests stopped completing after %0d requests", num_reqs);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      addr_t a;
      addr_t b;
      int    r;
      Rd     = 1'b0;
      Wr     = 1'b0;
      Addr   = '0;
      DataIn = '0;
      rst_n  = 1'b0;
      for (int s = 0; s < NUM_SETS; s++) begin
         ref_valid[0][s] = 1'b0;
         ref_valid[1][s] = 1'b0;
         ref_mru[s]      = 1'b0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (!Done && !Stall && !CacheHit && !err)
      else begin
         $display("Outputs not idle after reset");
         errors++;
      end

      // Cold miss followed by hits on the same line
      a = make_addr(5'h03, 8'h10, 2'd1);
      issue(1'b1, 1'b0, a, '0);
      issue(1'b1, 1'b0, a, '0);
      issue(1'b0, 1'b1, a, 16'h1234);
      issue(1'b1, 1'b0, a, '0);
      issue(1'b0, 1'b1, make_addr(5'h03, 8'h10, 2'd3), 16'h0abc);

      // Three tags in one set evict dirty lines from both ways
      issue(1'b0, 1'b1, make_addr(5'h01, 8'h20, 2'd0), 16'h1111);
      issue(1'b0, 1'b1, make_addr(5'h02, 8'h20, 2'd0), 16'h2222);
      issue(1'b1, 1'b0, make_addr(5'h01, 8'h20, 2'd0), '0);
      issue(1'b1, 1'b0, make_addr(5'h02, 8'h20, 2'd0), '0);
      issue(1'b1, 1'b0, make_addr(5'h07, 8'h20, 2'd2), '0);
      issue(1'b1, 1'b0, make_addr(5'h01, 8'h20, 2'd0), '0);
      issue(1'b1, 1'b0, make_addr(5'h02, 8'h20, 2'd0), '0);

      // Bad requests leave the cache alone
      issue(1'b1, 1'b1, a, 16'hdead);
      issue(1'b0, 1'b1, a | 16'h1, 16'hbeef);
      issue(1'b1, 1'b0, a | 16'h1, '0);
      issue(1'b1, 1'b0, a, '0);

      // DataOut holds the last read across a write
      issue(1'b0, 1'b1, make_addr(5'h07, 8'h20, 2'd2), 16'h5555);

      for (int i = 0; i < NUM_RAND; i++) begin
         b = make_addr(tag_t'($random(seed)), index_t'($random(seed) & IDX_MASK),
                       2'($random(seed)));
         r = $random(seed) & 15;
         if (r == 0) begin
            issue(1'b1, 1'b1, b, word_t'($random(seed)));
         end else if (r == 1) begin
            issue(1'b1, 1'b0, b | 16'h1, '0);
         end else begin
            issue(r[0], !r[0], b, word_t'($random(seed)));
         end
      end

      $display("Requests: %0d, checks: %0d, errors: %0d", num_reqs, checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: Bender.yml
package:
  name: mem_system

sources:
  - rtl/mem_sys_pkg.sv
  - rtl/cache_way_if.sv
  - rtl/cache_way.sv
  - rtl/four_bank_mem.sv
  - rtl/cache_ctrl_assoc.sv
  - rtl/mem_system.sv
  - target: test
    files:
      - test/tb_mem_system.sv

// File: tb.f
rtl/mem_sys_pkg.sv
rtl/cache_way_if.sv
rtl/cache_way.sv
rtl/four_bank_mem.sv
rtl/cache_ctrl_assoc.sv
rtl/mem_system.sv
test/tb_mem_system.sv
